// File: verilog/fetch_pkg.sv
package fetch_pkg;

    // ------------------------------------------------------------
    // Address and data
    // ------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // ------------------------------------------------------------
    // Cache geometry
    // ------------------------------------------------------------
    localparam int OFFSET_WIDTH   = 2;
    localparam int WORD_SEL_WIDTH = 1;
    localparam int LINE_WORDS     = 1 << WORD_SEL_WIDTH;
    localparam int INDEX_WIDTH    = 2;
    localparam int LINES          = 1 << INDEX_WIDTH;
    // Everything above the index is tag
    localparam int TAG_WIDTH      = 32 - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;

    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Cacheable regions
    localparam logic [3:0] REGION_FLASH_NIBBLE = 4'h3;
    localparam logic [7:0] REGION_SRAM_BYTE    = 8'ha0;

    // AXI burst types
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    // ------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        LOOKUP     = 3'd1,
        REFILL_REQ = 3'd2,
        REFILL     = 3'd3,
        RESPOND    = 3'd4,
        BYPASS     = 3'd5
    } ctrl_state_t;

endpackage

// File: verilog/icache_line_store.sv
`timescale 1ns/100ps

module icache_line_store (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 clr,

    // Lookup side
    input  fetch_pkg::index_t                    lookup_index,
    input  fetch_pkg::tag_t                      lookup_tag,
    input  logic [fetch_pkg::WORD_SEL_WIDTH-1:0] word_sel,
    output logic                                 lookup_hit,
    output fetch_pkg::word_t                     lookup_word,

    // Refill side
    input  logic                                 fill_we,
    input  logic [fetch_pkg::WORD_SEL_WIDTH-1:0] fill_beat,
    input  fetch_pkg::word_t                     fill_data,
    input  logic                                 fill_done
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    logic [fetch_pkg::LINES-1:0] valid;
    fetch_pkg::tag_t             tag_mem  [fetch_pkg::LINES];
    fetch_pkg::word_t            data_mem [fetch_pkg::LINES][fetch_pkg::LINE_WORDS];

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    // Invalid lines never hit, whatever the tag array holds
    assign lookup_hit  = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign lookup_word = data_mem[lookup_index][word_sel];

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else if (clr) begin
            // Invalidate wins over a finishing refill
            valid <= '0;
        end else if (fill_done) begin
            valid[lookup_index] <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Tag and data arrays
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (fill_we) begin
            data_mem[lookup_index][fill_beat] <= fill_data;
        end
        // Tag is written with the last beat
        if (fill_done) begin
            tag_mem[lookup_index] <= lookup_tag;
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                                 clock,
    input  logic                                 reset,

    // Fetch port
    input  logic                                 ifu_arvalid,
    output logic                                 ifu_arready,
    input  fetch_pkg::addr_t                     ifu_araddr,
    output logic                                 ifu_rvalid,
    input  logic                                 ifu_rready,
    output fetch_pkg::word_t                     ifu_rdata,
    output logic [1:0]                           ifu_rresp,
    output logic                                 ifu_rlast,

    // Memory port
    output logic                                 mem_arvalid,
    input  logic                                 mem_arready,
    output fetch_pkg::addr_t                     mem_araddr,
    output logic [7:0]                           mem_arlen,
    output logic [1:0]                           mem_arburst,
    input  logic                                 mem_rvalid,
    output logic                                 mem_rready,
    input  fetch_pkg::word_t                     mem_rdata,
    input  logic [1:0]                           mem_rresp,
    input  logic                                 mem_rlast,

    // Line store
    output fetch_pkg::index_t                    lookup_index,
    output fetch_pkg::tag_t                      lookup_tag,
    output logic [fetch_pkg::WORD_SEL_WIDTH-1:0] word_sel,
    input  logic                                 lookup_hit,
    input  fetch_pkg::word_t                     lookup_word,
    output logic                                 fill_we,
    output logic [fetch_pkg::WORD_SEL_WIDTH-1:0] fill_beat,
    output fetch_pkg::word_t                     fill_data,
    output logic                                 fill_done,

    // Performance events
    output logic                                 lookup_done,
    output logic                                 region_is_flash
);

    localparam int LINE_LSB = fetch_pkg::OFFSET_WIDTH + fetch_pkg::WORD_SEL_WIDTH;

    fetch_pkg::ctrl_state_t                state;
    fetch_pkg::addr_t                      req_addr;
    logic [fetch_pkg::WORD_SEL_WIDTH-1:0]  beat_cnt;
    logic                                  in_flash;
    logic                                  in_sram;
    logic                                  cacheable;
    fetch_pkg::addr_t                      line_addr;

    // Region decode on the incoming address
    assign in_flash  = (ifu_araddr[31:28] == fetch_pkg::REGION_FLASH_NIBBLE);
    assign in_sram   = (ifu_araddr[31:24] == fetch_pkg::REGION_SRAM_BYTE);
    assign cacheable = in_flash || in_sram;

    // Fields of the latched request
    assign lookup_index    = req_addr[LINE_LSB +: fetch_pkg::INDEX_WIDTH];
    assign lookup_tag      = req_addr[31 -: fetch_pkg::TAG_WIDTH];
    assign word_sel        = req_addr[fetch_pkg::OFFSET_WIDTH +: fetch_pkg::WORD_SEL_WIDTH];
    assign line_addr       = {req_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
    assign region_is_flash = (req_addr[31:28] == fetch_pkg::REGION_FLASH_NIBBLE);
    assign lookup_done     = (state == fetch_pkg::LOOKUP);

    // ------------------------------------------------------------
    // State, request address and beat counter
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= fetch_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                fetch_pkg::IDLE: begin
                    if (ifu_arvalid && ifu_arready) begin
                        state <= cacheable ? fetch_pkg::LOOKUP : fetch_pkg::BYPASS;
                    end
                end
                fetch_pkg::LOOKUP: begin
                    state <= lookup_hit ? fetch_pkg::RESPOND : fetch_pkg::REFILL_REQ;
                end
                fetch_pkg::REFILL_REQ: begin
                    if (mem_arready) begin
                        state    <= fetch_pkg::REFILL;
                        beat_cnt <= '0;
                    end
                end
                fetch_pkg::REFILL: begin
                    if (mem_rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem_rlast) begin
                            state <= fetch_pkg::RESPOND;
                        end
                    end
                end
                fetch_pkg::RESPOND: begin
                    // Held here while the fetch unit stalls
                    if (ifu_rready) begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                fetch_pkg::BYPASS: begin
                    if (mem_rvalid && ifu_rready && mem_rlast) begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == fetch_pkg::IDLE && ifu_arvalid && ifu_arready) begin
            req_addr <= ifu_araddr;
        end
    end

    // ------------------------------------------------------------
    // Channel drive
    // ------------------------------------------------------------
    always_comb begin
        ifu_arready = 1'b0;
        ifu_rvalid  = 1'b0;
        ifu_rdata   = lookup_word;
        ifu_rresp   = 2'b00;
        ifu_rlast   = 1'b0;
        mem_arvalid = 1'b0;
        mem_araddr  = line_addr;
        mem_arlen   = 8'(fetch_pkg::LINE_WORDS - 1);
        mem_arburst = fetch_pkg::BURST_INCR;
        mem_rready  = 1'b0;
        fill_we     = 1'b0;
        fill_beat   = beat_cnt;
        fill_data   = mem_rdata;
        fill_done   = 1'b0;
        case (state)
            fetch_pkg::IDLE: begin
                if (cacheable) begin
                    ifu_arready = 1'b1;
                end else begin
                    // Uncached address goes straight to memory
                    ifu_arready = mem_arready;
                    mem_arvalid = ifu_arvalid;
                    mem_araddr  = ifu_araddr;
                    mem_arlen   = 8'd0;
                    mem_arburst = fetch_pkg::BURST_FIXED;
                end
            end
            fetch_pkg::REFILL_REQ: begin
                mem_arvalid = 1'b1;
            end
            fetch_pkg::REFILL: begin
                mem_rready = 1'b1;
                fill_we    = mem_rvalid;
                fill_done  = mem_rvalid && mem_rlast;
            end
            fetch_pkg::RESPOND: begin
                ifu_rvalid = 1'b1;
                ifu_rlast  = 1'b1;
            end
            fetch_pkg::BYPASS: begin
                ifu_rvalid = mem_rvalid;
                ifu_rdata  = mem_rdata;
                ifu_rresp  = mem_rresp;
                ifu_rlast  = mem_rlast;
                mem_rready = ifu_rready;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/fetch_perf_counters.sv
`timescale 1ns/100ps

module fetch_perf_counters (
    input  logic        clock,
    input  logic        reset,
    input  logic        lookup_done,
    input  logic        lookup_hit,
    input  logic        region_is_flash,
    output logic [31:0] flash_hit,
    output logic [31:0] flash_miss,
    output logic [31:0] sram_hit,
    output logic [31:0] sram_miss
);

    logic flash_hit_ev;
    logic flash_miss_ev;
    logic sram_hit_ev;
    logic sram_miss_ev;

    // Exactly one event per lookup
    assign flash_hit_ev  = lookup_done &&  region_is_flash &&  lookup_hit;
    assign flash_miss_ev = lookup_done &&  region_is_flash && !lookup_hit;
    assign sram_hit_ev   = lookup_done && !region_is_flash &&  lookup_hit;
    assign sram_miss_ev  = lookup_done && !region_is_flash && !lookup_hit;

    // Counters wrap
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flash_hit  <= '0;
            flash_miss <= '0;
            sram_hit   <= '0;
            sram_miss  <= '0;
        end else begin
            if (flash_hit_ev)  flash_hit  <= flash_hit + 32'd1;
            if (flash_miss_ev) flash_miss <= flash_miss + 32'd1;
            if (sram_hit_ev)   sram_hit   <= sram_hit + 32'd1;
            if (sram_miss_ev)  sram_miss  <= sram_miss + 32'd1;
        end
    end

endmodule

// File: verilog/fetch_cache_top.sv
`timescale 1ns/100ps

module fetch_cache_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             clr,

    // Fetch port
    input  logic             ifu_arvalid,
    output logic             ifu_arready,
    input  fetch_pkg::addr_t ifu_araddr,
    output logic             ifu_rvalid,
    input  logic             ifu_rready,
    output fetch_pkg::word_t ifu_rdata,
    output logic [1:0]       ifu_rresp,
    output logic             ifu_rlast,

    // Memory port
    output logic             mem_arvalid,
    input  logic             mem_arready,
    output fetch_pkg::addr_t mem_araddr,
    output logic [7:0]       mem_arlen,
    output logic [1:0]       mem_arburst,
    input  logic             mem_rvalid,
    output logic             mem_rready,
    input  fetch_pkg::word_t mem_rdata,
    input  logic [1:0]       mem_rresp,
    input  logic             mem_rlast,

    // Hit and miss counters
    output logic [31:0]      flash_hit,
    output logic [31:0]      flash_miss,
    output logic [31:0]      sram_hit,
    output logic [31:0]      sram_miss
);

    // ------------------------------------------------------------
    // Controller to store and counters
    // ------------------------------------------------------------
    fetch_pkg::index_t                    lookup_index;
    fetch_pkg::tag_t                      lookup_tag;
    logic [fetch_pkg::WORD_SEL_WIDTH-1:0] word_sel;
    logic                                 lookup_hit;
    fetch_pkg::word_t                     lookup_word;
    logic                                 fill_we;
    logic [fetch_pkg::WORD_SEL_WIDTH-1:0] fill_beat;
    fetch_pkg::word_t                     fill_data;
    logic                                 fill_done;
    logic                                 lookup_done;
    logic                                 region_is_flash;

    icache_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .ifu_arvalid     (ifu_arvalid),
        .ifu_arready     (ifu_arready),
        .ifu_araddr      (ifu_araddr),
        .ifu_rvalid      (ifu_rvalid),
        .ifu_rready      (ifu_rready),
        .ifu_rdata       (ifu_rdata),
        .ifu_rresp       (ifu_rresp),
        .ifu_rlast       (ifu_rlast),
        .mem_arvalid     (mem_arvalid),
        .mem_arready     (mem_arready),
        .mem_araddr      (mem_araddr),
        .mem_arlen       (mem_arlen),
        .mem_arburst     (mem_arburst),
        .mem_rvalid      (mem_rvalid),
        .mem_rready      (mem_rready),
        .mem_rdata       (mem_rdata),
        .mem_rresp       (mem_rresp),
        .mem_rlast       (mem_rlast),
        .lookup_index    (lookup_index),
        .lookup_tag      (lookup_tag),
        .word_sel        (word_sel),
        .lookup_hit      (lookup_hit),
        .lookup_word     (lookup_word),
        .fill_we         (fill_we),
        .fill_beat       (fill_beat),
        .fill_data       (fill_data),
        .fill_done       (fill_done),
        .lookup_done     (lookup_done),
        .region_is_flash (region_is_flash)
    );

    icache_line_store u_store (
        .clock        (clock),
        .reset        (reset),
        .clr          (clr),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .lookup_hit   (lookup_hit),
        .lookup_word  (lookup_word),
        .fill_we      (fill_we),
        .fill_beat    (fill_beat),
        .fill_data    (fill_data),
        .fill_done    (fill_done)
    );

    fetch_perf_counters u_perf (
        .clock           (clock),
        .reset           (reset),
        .lookup_done     (lookup_done),
        .lookup_hit      (lookup_hit),
        .region_is_flash (region_is_flash),
        .flash_hit       (flash_hit),
        .flash_miss      (flash_miss),
        .sram_hit        (sram_hit),
        .sram_miss       (sram_miss)
    );

endmodule

// File: dv/axi_read_mem_model.sv
`timescale 1ns/100ps

module axi_read_mem_model (
    input  logic             clock,
    input  logic             reset,
    input  logic             arvalid,
    output logic             arready,
    input  fetch_pkg::addr_t araddr,
    input  logic [7:0]       arlen,
    input  logic [1:0]       arburst,
    output logic             rvalid,
    input  logic             rready,
    output fetch_pkg::word_t rdata,
    output logic [1:0]       rresp,
    output logic             rlast
);

    integer           seed;
    logic             busy;
    logic             incr;
    logic             ar_fire;
    logic             r_fire;
    fetch_pkg::addr_t ar_addr_s;
    logic [7:0]       ar_len_s;
    logic [1:0]       ar_burst_s;
    fetch_pkg::addr_t beat_addr;
    logic [7:0]       beats_left;
    int               wait_cnt;

    initial begin
        seed       = 48;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = 2'b00;
        rlast      = 1'b0;
        busy       = 1'b0;
        incr       = 1'b0;
        beat_addr  = '0;
        beats_left = 8'd0;
        wait_cnt   = 0;
        forever begin
            @(posedge clock);
            // Handshakes as they stood at the edge
            ar_fire    = arvalid && arready;
            r_fire     = rvalid && rready;
            ar_addr_s  = araddr;
            ar_len_s   = arlen;
            ar_burst_s = arburst;
            #2;
            if (reset) begin
                busy     = 1'b0;
                arready  = 1'b0;
                rvalid   = 1'b0;
                rlast    = 1'b0;
                wait_cnt = 0;
            end else begin
                if (ar_fire) begin
                    busy       = 1'b1;
                    arready    = 1'b0;
                    beat_addr  = ar_addr_s;
                    beats_left = ar_len_s;
                    incr       = (ar_burst_s == fetch_pkg::BURST_INCR);
                    wait_cnt   = $random(seed) & 3;
                end else if (r_fire) begin
                    rvalid   = 1'b0;
                    busy     = !rlast;
                    wait_cnt = $random(seed) & 3;
                    if (!rlast) begin
                        beats_left = beats_left - 8'd1;
                        if (incr) begin
                            beat_addr = beat_addr + 32'd4;
                        end
                    end
                end
                // Stall of 0 to 3 cycles before each ready or valid
                if (!busy) begin
                    if (wait_cnt > 0) begin
                        wait_cnt = wait_cnt - 1;
                    end else begin
                        arready = 1'b1;
                    end
                end else if (!rvalid) begin
                    if (wait_cnt > 0) begin
                        wait_cnt = wait_cnt - 1;
                    end else begin
                        rvalid = 1'b1;
                        rdata  = ~beat_addr;
                        rresp  = 2'b00;
                        rlast  = (beats_left == 8'd0);
                    end
                end
            end
        end
    end

endmodule

// File: dv/fetch_cache_tb.sv
`timescale 1ns/100ps

module fetch_cache_tb;

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 4;
    // Memory model stalls at most 3 cycles per handshake
    localparam int STALL_MAX    = 3;
    localparam int FETCHES      = 10;
    localparam int FETCH_WORST  = (STALL_MAX + 1) * (2 + fetch_pkg::LINE_WORDS) + 6 + HOLD_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 4 + FETCHES * FETCH_WORST);

    localparam fetch_pkg::addr_t SRAM_ADDR   = 32'ha000_0014;
    localparam fetch_pkg::addr_t SRAM_OTHER  = 32'ha000_0010;
    localparam fetch_pkg::addr_t SRAM_FAR    = 32'ha000_0040;
    localparam fetch_pkg::addr_t FLASH_A     = 32'h3000_0100;
    localparam fetch_pkg::addr_t FLASH_B     = 32'h3000_0200;
    localparam fetch_pkg::addr_t BYPASS_ADDR = 32'h4000_1230;

    // AXI response code for a good transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic clock = 1'b0;
    logic reset;
    logic clr;
    logic ifu_arvalid;
    logic ifu_arready;
    logic ifu_rvalid;
    logic ifu_rready;
    logic ifu_rlast;
    fetch_pkg::addr_t ifu_araddr;
    fetch_pkg::word_t ifu_rdata;
    logic [1:0] ifu_rresp;
    logic mem_arvalid;
    logic mem_arready;
    logic mem_rvalid;
    logic mem_rready;
    logic mem_rlast;
    fetch_pkg::addr_t mem_araddr;
    logic [7:0] mem_arlen;
    logic [1:0] mem_arburst;
    logic [1:0] mem_rresp;
    fetch_pkg::word_t mem_rdata;
    logic [31:0] flash_hit;
    logic [31:0] flash_miss;
    logic [31:0] sram_hit;
    logic [31:0] sram_miss;

    // Expected counters and memory port bookkeeping
    logic [31:0] exp_flash_hit = '0;
    logic [31:0] exp_flash_miss = '0;
    logic [31:0] exp_sram_hit = '0;
    logic [31:0] exp_sram_miss = '0;
    int burst_count = 0;
    int beat_count = 0;
    fetch_pkg::addr_t last_ar_addr = '0;
    logic [7:0] last_ar_len = '0;
    logic [1:0] last_ar_burst = '0;
    int error_count = 0;
    int test_count = 0;
    int tests_failed = 0;

    fetch_cache_top u_dut (
        .clock(clock), .reset(reset), .clr(clr),
        .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready), .ifu_araddr(ifu_araddr),
        .ifu_rvalid(ifu_rvalid), .ifu_rready(ifu_rready), .ifu_rdata(ifu_rdata),
        .ifu_rresp(ifu_rresp), .ifu_rlast(ifu_rlast),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_araddr(mem_araddr),
        .mem_arlen(mem_arlen), .mem_arburst(mem_arburst),
        .mem_rvalid(mem_rvalid), .mem_rready(mem_rready), .mem_rdata(mem_rdata),
        .mem_rresp(mem_rresp), .mem_rlast(mem_rlast),
        .flash_hit(flash_hit), .flash_miss(flash_miss),
        .sram_hit(sram_hit), .sram_miss(sram_miss)
    );

    axi_read_mem_model u_mem (
        .clock(clock), .reset(reset),
        .arvalid(mem_arvalid), .arready(mem_arready), .araddr(mem_araddr),
        .arlen(mem_arlen), .arburst(mem_arburst),
        .rvalid(mem_rvalid), .rready(mem_rready), .rdata(mem_rdata),
        .rresp(mem_rresp), .rlast(mem_rlast)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Requests and beats seen at the memory port
    always @(posedge clock) begin
        if (!reset && mem_arvalid && mem_arready) begin
            burst_count   <= burst_count + 1;
            last_ar_addr  <= mem_araddr;
            last_ar_len   <= mem_arlen;
            last_ar_burst <= mem_arburst;
        end
        if (!reset && mem_rvalid && mem_rready) begin
            beat_count <= beat_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired after %0d cycles with the controller in %s",
                 WATCHDOG_CYCLES, u_dut.u_ctrl.state.name());
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string what, input fetch_pkg::word_t got,
                              input fetch_pkg::word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bool(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_counters(input string what);
        check_count({what, " flash_hit"}, flash_hit, exp_flash_hit);
        check_count({what, " flash_miss"}, flash_miss, exp_flash_miss);
        check_count({what, " sram_hit"}, sram_hit, exp_sram_hit);
        check_count({what, " sram_miss"}, sram_miss, exp_sram_miss);
    endtask

    function automatic fetch_pkg::addr_t line_base(input fetch_pkg::addr_t addr);
        return addr & ~fetch_pkg::addr_t'(fetch_pkg::LINE_WORDS * 4 - 1);
    endfunction

    task automatic check_refill(input string what, input int bursts0, input int beats0,
                                input fetch_pkg::addr_t addr);
        check_count({what, " bursts"}, 32'(burst_count - bursts0), 32'd1);
        check_count({what, " beats"}, 32'(beat_count - beats0), 32'(fetch_pkg::LINE_WORDS));
        check_word({what, " burst address"}, last_ar_addr, line_base(addr));
        check_count({what, " arlen"}, 32'(last_ar_len), 32'(fetch_pkg::LINE_WORDS - 1));
        check_bool({what, " INCR burst"}, last_ar_burst == fetch_pkg::BURST_INCR, 1'b1);
    endtask

    // ------------------------------------------------------------
    // Fetch with optional back-pressure on the reply
    // ------------------------------------------------------------
    task automatic fetch(input fetch_pkg::addr_t addr, input int hold);
        logic seen;
        fetch_pkg::word_t held;
        seen = 1'b0;
        ifu_arvalid = 1'b1;
        ifu_araddr  = addr;
        while (!seen) begin
            @(posedge clock);
            seen = ifu_arready;
        end
        #2;
        ifu_arvalid = 1'b0;
        if (hold > 0) begin
            seen = 1'b0;
            while (!seen) begin
                @(posedge clock);
                seen = ifu_rvalid;
            end
            held = ifu_rdata;
            repeat (hold) begin
                @(posedge clock);
                check_bool("rvalid while stalled", ifu_rvalid, 1'b1);
                check_bool("arready while stalled", ifu_arready, 1'b0);
                check_word("rdata while stalled", ifu_rdata, held);
            end
            #2;
        end
        ifu_rready = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clock);
            seen = ifu_rvalid;
        end
        // Memory data is the inverted beat address
        check_word("fetched word", ifu_rdata, ~addr);
        check_bool("rlast", ifu_rlast, 1'b1);
        // The memory model always answers OKAY
        check_resp("rresp", ifu_rresp, RESP_OKAY);
        #2;
        ifu_rready = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors0);
        test_count++;
        if (error_count == errors0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors0);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic cold_sram_fetch();
        int errors0;
        int bursts0;
        int beats0;
        errors0 = error_count;
        bursts0 = burst_count;
        beats0  = beat_count;
        fetch(SRAM_ADDR, 0);
        check_refill("cold sram", bursts0, beats0, SRAM_ADDR);
        exp_sram_miss = exp_sram_miss + 32'd1;
        check_counters("cold sram");
        finish_test("cold SRAM fetch", errors0);
    endtask

    task automatic same_line_hit();
        int errors0;
        int bursts0;
        errors0 = error_count;
        bursts0 = burst_count;
        fetch(SRAM_OTHER, 0);
        check_count("same line bursts", 32'(burst_count - bursts0), 32'd0);
        exp_sram_hit = exp_sram_hit + 32'd1;
        check_counters("same line");
        finish_test("same line hit", errors0);
    endtask

    task automatic flash_conflict();
        int errors0;
        int bursts0;
        int beats0;
        fetch_pkg::addr_t addr;
        errors0 = error_count;
        // Both lines map to index 0 and keep evicting each other
        for (int i = 0; i < 4; i++) begin
            addr    = (i % 2 == 0) ? FLASH_A : FLASH_B;
            bursts0 = burst_count;
            beats0  = beat_count;
            fetch(addr, 0);
            check_refill("flash conflict", bursts0, beats0, addr);
            exp_flash_miss = exp_flash_miss + 32'd1;
        end
        check_counters("flash conflict");
        finish_test("flash index conflict", errors0);
    endtask

    task automatic bypass_fetch();
        int errors0;
        int bursts0;
        int beats0;
        errors0 = error_count;
        bursts0 = burst_count;
        beats0  = beat_count;
        fetch(BYPASS_ADDR, 0);
        check_count("bypass bursts", 32'(burst_count - bursts0), 32'd1);
        check_count("bypass beats", 32'(beat_count - beats0), 32'd1);
        check_word("bypass address", last_ar_addr, BYPASS_ADDR);
        check_count("bypass arlen", 32'(last_ar_len), 32'd0);
        check_bool("bypass FIXED burst", last_ar_burst == fetch_pkg::BURST_FIXED, 1'b1);
        check_counters("bypass");
        finish_test("bypass fetch", errors0);
    endtask

    task automatic clear_and_refetch();
        int errors0;
        int bursts0;
        int beats0;
        errors0 = error_count;
        clr = 1'b1;
        @(posedge clock);
        #2;
        clr = 1'b0;
        bursts0 = burst_count;
        beats0  = beat_count;
        fetch(SRAM_OTHER, 0);
        check_refill("after clr", bursts0, beats0, SRAM_OTHER);
        exp_sram_miss = exp_sram_miss + 32'd1;
        check_counters("after clr");
        finish_test("clear and refetch", errors0);
    endtask

    task automatic rready_backpressure();
        int errors0;
        int bursts0;
        int beats0;
        errors0 = error_count;
        bursts0 = burst_count;
        fetch(SRAM_ADDR, HOLD_CYCLES);
        check_count("stalled hit bursts", 32'(burst_count - bursts0), 32'd0);
        exp_sram_hit = exp_sram_hit + 32'd1;
        bursts0 = burst_count;
        beats0  = beat_count;
        fetch(SRAM_FAR, HOLD_CYCLES);
        check_refill("stalled miss", bursts0, beats0, SRAM_FAR);
        exp_sram_miss = exp_sram_miss + 32'd1;
        check_counters("back-pressure");
        finish_test("rready back-pressure", errors0);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        reset       = 1'b1;
        clr         = 1'b0;
        ifu_arvalid = 1'b0;
        ifu_araddr  = '0;
        ifu_rready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        check_counters("after reset");
        cold_sram_fetch();
        same_line_hit();
        flash_conflict();
        bypass_fetch();
        clear_and_refetch();
        rready_backpressure();
        $display("%0d tests run, %0d failed, %0d errors", test_count, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/fetch_pkg.sv
verilog/icache_line_store.sv
verilog/icache_ctrl.sv
verilog/fetch_perf_counters.sv
verilog/fetch_cache_top.sv
dv/axi_read_mem_model.sv
dv/fetch_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_cache_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vfetch_cache_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
